/* cache_bank.f */
source/bank_pkg.sv
source/bank_htu.sv
source/bank_sram_controller.sv
source/bank_beat_counter.sv
source/bank_data_sram.sv
source/bank_wbuffer.sv
source/bank_top.sv
test/tb_clock_gen.sv
test/bank_tb.sv

/* source/bank_beat_counter.sv */
`default_nettype none

module bank_beat_counter (
  input  wire  clk_i,
  input  wire  rst_i,
  input  wire  clr_i,
  input  wire  adv_i,
  output logic beat_o,
  output logic last_o
);

  logic beat_q;

  // Two beats per line, so one bit wraps on its own
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      beat_q <= 1'b0;
    end else if (clr_i) begin
      beat_q <= 1'b0;
    end else if (adv_i) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  assign beat_o = beat_q;
  assign last_o = (beat_q == 1'b1);

endmodule

`default_nettype wire

/* source/bank_data_sram.sv */
`default_nettype none

module bank_data_sram #(
  parameter int SET_BITS = 4
) (
  input  wire                            clk_i,
  input  wire                            rd_i,
  input  wire                            wr_i,
  input  wire  [SET_BITS-1:0]            set_i,
  input  wire                            way_i,
  input  wire                            beat_i,
  input  wire  [bank_pkg::BEAT_W-1:0]    wdata_i,
  output logic [bank_pkg::BEAT_W-1:0]    rdata_o
);

  import bank_pkg::*;

  localparam int DEPTH = (1 << SET_BITS) * NUM_WAYS * 2;

  logic [BEAT_W-1:0]   mem_q [DEPTH];
  logic [SET_BITS+1:0] addr;

  // Set, then way, then beat
  assign addr = {set_i, way_i, beat_i};

  // Read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      mem_q[addr] <= wdata_i;
    end
    if (rd_i) begin
      rdata_o <= mem_q[addr];
    end
  end

endmodule

`default_nettype wire

/* source/bank_htu.sv */
`default_nettype none

module bank_htu #(
  parameter int SET_BITS = 4
) (
  input  wire                                clk_i,
  input  wire                                rst_i,
  input  wire                                lookup_i,
  input  wire  [bank_pkg::LINE_ADDR_W-1:0]   line_addr_i,
  output bank_pkg::lookup_t                  lookup_o,
  input  wire                                update_i,
  input  wire  bank_pkg::bank_op_e           update_op_i,
  input  wire                                update_way_i
);

  import bank_pkg::*;

  localparam int NUM_SETS = 1 << SET_BITS;
  localparam int TAG_W    = LINE_ADDR_W - SET_BITS;

  logic [TAG_W-1:0]    tag_q [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
  logic [NUM_SETS-1:0] victim_q;

  logic [SET_BITS-1:0] set_idx;
  logic [TAG_W-1:0]    tag;
  lookup_t             lookup_c;
  lookup_t             lookup_q;

  // Same address serves lookup and update, the controller holds it
  assign set_idx = line_addr_i[SET_BITS-1:0];
  assign tag     = line_addr_i[LINE_ADDR_W-1:SET_BITS];

  // Compare against both ways, fall back to the victim on a miss
  always_comb begin
    lookup_c.hit = 1'b0;
    lookup_c.way = victim_q[set_idx];
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (valid_q[set_idx][w] && (tag_q[set_idx][w] == tag)) begin
        lookup_c.hit = 1'b1;
        lookup_c.way = 1'(w);
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      lookup_q <= '0;
    end else if (lookup_i) begin
      lookup_q <= lookup_c;
    end
  end

  assign lookup_o = lookup_q;

  always_ff @(posedge clk_i) begin
    if (update_i && (update_op_i == OP_WRITE)) begin
      tag_q[set_idx][update_way_i] <= tag;
    end
  end

  // Hit status of the update comes from the registered lookup
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q  <= '{default: '0};
      victim_q <= '0;
    end else if (update_i) begin
      case (update_op_i)
        OP_WRITE: begin
          valid_q[set_idx][update_way_i] <= 1'b1;
          // Allocation on a miss moves the victim to the other way
          if (!lookup_q.hit) begin
            victim_q[set_idx] <= ~victim_q[set_idx];
          end
        end
        OP_INVAL: begin
          if (lookup_q.hit) begin
            valid_q[set_idx][update_way_i] <= 1'b0;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/bank_pkg.sv */
`default_nettype none

package bank_pkg;

  // Line address is byte address bits 31:5
  localparam int LINE_ADDR_W = 27;
  localparam int BEAT_W      = 128;
  localparam int CH_ID_W     = 2;
  localparam int WBUF_ID_W   = 8;

  // Two ways, the victim pointer is a single bit per set
  localparam int NUM_WAYS    = 2;

  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_INVAL = 2'd2
  } bank_op_e;

  typedef struct packed {
    logic [CH_ID_W-1:0]     ch_id;
    bank_op_e               op;
    logic [LINE_ADDR_W-1:0] line_addr;
    logic [WBUF_ID_W-1:0]   wbuf_id;
  } bank_req_t;

  typedef struct packed {
    logic [CH_ID_W-1:0] ch_id;
    bank_op_e           op;
    logic               hit;
    logic               beat;
    logic               last;
    logic [BEAT_W-1:0]  data;
  } bank_resp_t;

  typedef struct packed {
    logic [WBUF_ID_W-1:0] wbuf_id;
    logic                 beat;
    logic [BEAT_W-1:0]    data;
  } wbuf_fill_t;

  typedef struct packed {
    logic hit;
    logic way;
  } lookup_t;

endpackage

`default_nettype wire

/* source/bank_sram_controller.sv */
`default_nettype none

module bank_sram_controller #(
  parameter int SET_BITS = 4
) (
  input  wire                                   clk_i,
  input  wire                                   rst_i,
  input  wire                                   req_valid_i,
  output logic                                  req_ready_o,
  input  wire  bank_pkg::bank_req_t             req_i,
  output logic                                  resp_valid_o,
  input  wire                                   resp_ready_i,
  output bank_pkg::bank_resp_t                  resp_o,
  output logic                                  lookup_o,
  output logic [bank_pkg::LINE_ADDR_W-1:0]      line_addr_o,
  input  wire  bank_pkg::lookup_t               lookup_i,
  output logic                                  update_o,
  output bank_pkg::bank_op_e                    update_op_o,
  output logic                                  update_way_o,
  output logic                                  wbuf_req_valid_o,
  input  wire                                   wbuf_req_ready_i,
  output logic [bank_pkg::WBUF_ID_W-1:0]        wbuf_req_id_o,
  input  wire                                   wbuf_rtn_valid_i,
  output logic                                  wbuf_rtn_ready_o,
  input  wire  [1:0][bank_pkg::BEAT_W-1:0]      wbuf_rtn_data_i,
  output logic                                  sram_rd_o,
  output logic                                  sram_wr_o,
  output logic [SET_BITS-1:0]                   sram_set_o,
  output logic                                  sram_way_o,
  output logic                                  sram_beat_o,
  output logic [bank_pkg::BEAT_W-1:0]           sram_wdata_o,
  input  wire  [bank_pkg::BEAT_W-1:0]           sram_rdata_i,
  output logic                                  beat_clr_o,
  output logic                                  beat_adv_o,
  input  wire                                   beat_i,
  input  wire                                   beat_last_i
);

  import bank_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_FETCH,
    S_WRITE,
    S_READ,
    S_RESP
  } state_e;

  state_e            state_q;
  state_e            state_d;
  bank_req_t         req_q;
  logic              resp_valid_q;
  logic [BEAT_W-1:0] resp_data_q;
  logic              fetch_sent_q;
  logic              accept;
  logic              resp_fire;
  logic              resp_last;
  logic              enter_resp;
  logic              is_read;
  logic [BEAT_W-1:0] beat_data;

  assign req_ready_o = (state_q == S_IDLE);
  assign accept      = req_valid_i && req_ready_o;
  assign is_read     = (req_q.op == OP_READ);
  assign resp_fire   = resp_valid_q && resp_ready_i;
  // Acks are a single beat
  assign resp_last   = !is_read || beat_last_i;
  assign enter_resp  = (state_d == S_RESP) && (state_q != S_RESP);
  // Zero data on a read miss
  assign beat_data   = lookup_i.hit ? sram_rdata_i : '0;

  assign lookup_o     = (state_q == S_LOOKUP);
  assign line_addr_o  = req_q.line_addr;
  assign update_o     = ((state_q == S_WRITE) && beat_last_i) ||
                        ((state_q == S_READ) && (req_q.op == OP_INVAL));
  assign update_op_o  = req_q.op;
  assign update_way_o = lookup_i.way;

  assign wbuf_req_valid_o = (state_q == S_FETCH) && !fetch_sent_q;
  assign wbuf_req_id_o    = req_q.wbuf_id;
  // Return is released once its second beat is in the array
  assign wbuf_rtn_ready_o = (state_q == S_WRITE) && beat_last_i;

  assign sram_rd_o    = (state_q == S_READ) && is_read && lookup_i.hit;
  assign sram_wr_o    = (state_q == S_WRITE);
  assign sram_set_o   = req_q.line_addr[SET_BITS-1:0];
  assign sram_way_o   = lookup_i.way;
  assign sram_beat_o  = beat_i;
  assign sram_wdata_o = wbuf_rtn_data_i[beat_i];

  // Counter wraps back to zero by the time RESP is entered
  assign beat_clr_o = (state_q == S_IDLE);
  assign beat_adv_o = (state_q == S_WRITE) ||
                      ((state_q == S_READ) && is_read) ||
                      (resp_fire && !resp_last);

  assign resp_valid_o = resp_valid_q;

  always_comb begin
    resp_o.ch_id = req_q.ch_id;
    resp_o.op    = req_q.op;
    resp_o.hit   = lookup_i.hit;
    resp_o.beat  = beat_i;
    resp_o.last  = resp_last;
    resp_o.data  = resp_data_q;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:   if (accept) state_d = S_LOOKUP;
      S_LOOKUP: state_d = (req_q.op == OP_WRITE) ? S_FETCH : S_READ;
      S_FETCH:  if (fetch_sent_q && wbuf_rtn_valid_i) state_d = S_WRITE;
      S_WRITE:  if (beat_last_i) state_d = S_RESP;
      // Invalidate spends one cycle here for its tag update
      S_READ:   if (!is_read || beat_last_i) state_d = S_RESP;
      S_RESP:   if (resp_fire && resp_last) state_d = S_IDLE;
      default:  state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q      <= S_IDLE;
      resp_valid_q <= 1'b0;
      fetch_sent_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (enter_resp) begin
        resp_valid_q <= 1'b1;
      end else if (resp_fire && resp_last) begin
        resp_valid_q <= 1'b0;
      end
      if (wbuf_req_valid_o && wbuf_req_ready_i) begin
        fetch_sent_q <= 1'b1;
      end else if (state_d != S_FETCH) begin
        fetch_sent_q <= 1'b0;
      end
    end
  end

  // First read beat arrives while beat 1 is being read
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    if (enter_resp) begin
      resp_data_q <= is_read ? beat_data : '0;
    end else if (resp_fire && !resp_last) begin
      resp_data_q <= beat_data;
    end
  end

endmodule

`default_nettype wire

/* source/bank_top.sv */
`default_nettype none

module bank_top #(
  parameter int SET_BITS     = 4,
  parameter int WBUF_ENTRIES = 16
) (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          req_valid_i,
  output logic                         req_ready_o,
  input  wire  bank_pkg::bank_req_t    req_i,
  input  wire                          wbuf_fill_valid_i,
  input  wire  bank_pkg::wbuf_fill_t   wbuf_fill_i,
  output logic                         resp_valid_o,
  input  wire                          resp_ready_i,
  output bank_pkg::bank_resp_t         resp_o
);

  import bank_pkg::*;

  // Controller to hit test unit
  logic                   lookup;
  logic [LINE_ADDR_W-1:0] line_addr;
  lookup_t                lookup_res;
  logic                   update;
  bank_op_e               update_op;
  logic                   update_way;

  // Controller to write buffer
  logic                   wbuf_req_valid;
  logic                   wbuf_req_ready;
  logic [WBUF_ID_W-1:0]   wbuf_req_id;
  logic                   wbuf_rtn_valid;
  logic                   wbuf_rtn_ready;
  logic [1:0][BEAT_W-1:0] wbuf_rtn_data;

  // Controller to data array
  logic                   sram_rd;
  logic                   sram_wr;
  logic [SET_BITS-1:0]    sram_set;
  logic                   sram_way;
  logic                   sram_beat;
  logic [BEAT_W-1:0]      sram_wdata;
  logic [BEAT_W-1:0]      sram_rdata;

  logic                   beat_clr;
  logic                   beat_adv;
  logic                   beat;
  logic                   beat_last;

  bank_htu #(
    .SET_BITS(SET_BITS)
  ) u_bank_htu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .lookup_i    (lookup),
    .line_addr_i (line_addr),
    .lookup_o    (lookup_res),
    .update_i    (update),
    .update_op_i (update_op),
    .update_way_i(update_way)
  );

  bank_sram_controller #(
    .SET_BITS(SET_BITS)
  ) u_bank_sram_controller (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_i           (req_i),
    .resp_valid_o    (resp_valid_o),
    .resp_ready_i    (resp_ready_i),
    .resp_o          (resp_o),
    .lookup_o        (lookup),
    .line_addr_o     (line_addr),
    .lookup_i        (lookup_res),
    .update_o        (update),
    .update_op_o     (update_op),
    .update_way_o    (update_way),
    .wbuf_req_valid_o(wbuf_req_valid),
    .wbuf_req_ready_i(wbuf_req_ready),
    .wbuf_req_id_o   (wbuf_req_id),
    .wbuf_rtn_valid_i(wbuf_rtn_valid),
    .wbuf_rtn_ready_o(wbuf_rtn_ready),
    .wbuf_rtn_data_i (wbuf_rtn_data),
    .sram_rd_o       (sram_rd),
    .sram_wr_o       (sram_wr),
    .sram_set_o      (sram_set),
    .sram_way_o      (sram_way),
    .sram_beat_o     (sram_beat),
    .sram_wdata_o    (sram_wdata),
    .sram_rdata_i    (sram_rdata),
    .beat_clr_o      (beat_clr),
    .beat_adv_o      (beat_adv),
    .beat_i          (beat),
    .beat_last_i     (beat_last)
  );

  bank_beat_counter u_bank_beat_counter (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .clr_i (beat_clr),
    .adv_i (beat_adv),
    .beat_o(beat),
    .last_o(beat_last)
  );

  bank_data_sram #(
    .SET_BITS(SET_BITS)
  ) u_bank_data_sram (
    .clk_i  (clk_i),
    .rd_i   (sram_rd),
    .wr_i   (sram_wr),
    .set_i  (sram_set),
    .way_i  (sram_way),
    .beat_i (sram_beat),
    .wdata_i(sram_wdata),
    .rdata_o(sram_rdata)
  );

  bank_wbuffer #(
    .WBUF_ENTRIES(WBUF_ENTRIES)
  ) u_bank_wbuffer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fill_valid_i(wbuf_fill_valid_i),
    .fill_i      (wbuf_fill_i),
    .req_valid_i (wbuf_req_valid),
    .req_ready_o (wbuf_req_ready),
    .req_id_i    (wbuf_req_id),
    .rtn_valid_o (wbuf_rtn_valid),
    .rtn_ready_i (wbuf_rtn_ready),
    .rtn_data_o  (wbuf_rtn_data)
  );

endmodule

`default_nettype wire

/* source/bank_wbuffer.sv */
`default_nettype none

module bank_wbuffer #(
  parameter int WBUF_ENTRIES = 16
) (
  input  wire                                  clk_i,
  input  wire                                  rst_i,
  input  wire                                  fill_valid_i,
  input  wire  bank_pkg::wbuf_fill_t           fill_i,
  input  wire                                  req_valid_i,
  output logic                                 req_ready_o,
  input  wire  [bank_pkg::WBUF_ID_W-1:0]       req_id_i,
  output logic                                 rtn_valid_o,
  input  wire                                  rtn_ready_i,
  output logic [1:0][bank_pkg::BEAT_W-1:0]     rtn_data_o
);

  import bank_pkg::*;

  localparam int IDX_W = $clog2(WBUF_ENTRIES);

  logic [1:0][BEAT_W-1:0] mem_q [WBUF_ENTRIES];
  logic [IDX_W-1:0]       fill_idx;
  logic [IDX_W-1:0]       req_idx;
  logic                   req_fire;

  // Low id bits pick the entry
  assign fill_idx = fill_i.wbuf_id[IDX_W-1:0];
  assign req_idx  = req_id_i[IDX_W-1:0];

  // One return in flight at a time
  assign req_ready_o = !rtn_valid_o;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (fill_valid_i) begin
      mem_q[fill_idx][fill_i.beat] <= fill_i.data;
    end
    if (req_fire) begin
      rtn_data_o <= mem_q[req_idx];
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rtn_valid_o <= 1'b0;
    end else if (req_fire) begin
      rtn_valid_o <= 1'b1;
    end else if (rtn_ready_i) begin
      rtn_valid_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* test/bank_tb.sv */
`default_nettype none

module bank_tb;

  import bank_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int SET_BITS     = 4;
  localparam int WBUF_ENTRIES = 16;
  localparam int NUM_SETS     = 1 << SET_BITS;
  localparam int TAG_W        = LINE_ADDR_W - SET_BITS;
  localparam int READ_LATENCY = 4;
  localparam int MAX_STALL    = 7;

  // Watchdog budget summed over all tests
  localparam int RESET_CYCLES    = 3;
  localparam int NUM_REQS        = 26;
  localparam int NUM_FILLS       = 6;
  localparam int REQ_CYCLES      = 16;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 + NUM_FILLS * 3 +
                                   NUM_REQS * (REQ_CYCLES + 2 * (MAX_STALL + 1));

  logic       clk;
  logic       rst;
  logic       req_valid;
  logic       req_ready;
  bank_req_t  req_in;
  logic       fill_valid;
  wbuf_fill_t fill;
  logic       resp_valid;
  logic       resp_ready;
  bank_resp_t resp;

  integer     seed = 32'h5d88_a974;
  bank_resp_t exp_q[$];

  // Reference cache state
  logic [TAG_W-1:0]  m_tag    [NUM_SETS][NUM_WAYS];
  logic              m_valid  [NUM_SETS][NUM_WAYS];
  logic              m_victim [NUM_SETS];
  logic [BEAT_W-1:0] m_data   [NUM_SETS][NUM_WAYS][2];
  logic [BEAT_W-1:0] m_wbuf   [WBUF_ENTRIES][2];

  tb_clock_gen #(
    .PERIOD(CLK_PERIOD)
  ) u_clock_gen (
    .clk_o(clk)
  );

  bank_top #(
    .SET_BITS    (SET_BITS),
    .WBUF_ENTRIES(WBUF_ENTRIES)
  ) u_bank_top (
    .clk_i            (clk),
    .rst_i            (rst),
    .req_valid_i      (req_valid),
    .req_ready_o      (req_ready),
    .req_i            (req_in),
    .wbuf_fill_valid_i(fill_valid),
    .wbuf_fill_i      (fill),
    .resp_valid_o     (resp_valid),
    .resp_ready_i     (resp_ready),
    .resp_o           (resp)
  );

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic compare_resp(input string name, input bank_resp_t got, input bank_resp_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic verify_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [LINE_ADDR_W-1:0] line_addr_of(input int tag, input int set);
    logic [TAG_W-1:0]    t;
    logic [SET_BITS-1:0] s;
    t = TAG_W'(tag);
    s = SET_BITS'(set);
    return {t, s};
  endfunction

  function automatic bank_req_t make_req(input int ch, input bank_op_e op,
                                         input logic [LINE_ADDR_W-1:0] addr, input int id);
    bank_req_t r;
    r.ch_id     = CH_ID_W'(ch);
    r.op        = op;
    r.line_addr = addr;
    r.wbuf_id   = WBUF_ID_W'(id);
    return r;
  endfunction

  function automatic logic [BEAT_W-1:0] random_beat();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic int draw_stall();
    return $unsigned($random(seed)) % (MAX_STALL + 1);
  endfunction

  function automatic void clear_reference();
    for (int s = 0; s < NUM_SETS; s++) begin
      m_victim[s] = 1'b0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
      end
    end
  endfunction

  // Apply one request to the reference and queue the beats it should produce
  function automatic void predict_response(input bank_req_t req);
    logic [SET_BITS-1:0] set;
    logic [TAG_W-1:0]    tag;
    logic                hit;
    logic                way;
    int                  idx;
    bank_resp_t          r;
    set = req.line_addr[SET_BITS-1:0];
    tag = req.line_addr[LINE_ADDR_W-1:SET_BITS];
    hit = 1'b0;
    way = m_victim[set];
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_valid[set][w] && (m_tag[set][w] == tag)) begin
        hit = 1'b1;
        way = 1'(w);
      end
    end
    r.ch_id = req.ch_id;
    r.op    = req.op;
    r.hit   = hit;
    r.beat  = 1'b0;
    r.last  = 1'b1;
    r.data  = '0;
    case (req.op)
      OP_READ: begin
        r.last = 1'b0;
        r.data = hit ? m_data[set][way][0] : '0;
        exp_q.push_back(r);
        r.beat = 1'b1;
        r.last = 1'b1;
        r.data = hit ? m_data[set][way][1] : '0;
        exp_q.push_back(r);
      end
      OP_WRITE: begin
        idx = req.wbuf_id % WBUF_ENTRIES;
        if (!hit) begin
          m_victim[set] = ~m_victim[set];
        end
        m_tag[set][way]     = tag;
        m_valid[set][way]   = 1'b1;
        m_data[set][way][0] = m_wbuf[idx][0];
        m_data[set][way][1] = m_wbuf[idx][1];
        exp_q.push_back(r);
      end
      default: begin
        if (hit) begin
          m_valid[set][way] = 1'b0;
        end
        exp_q.push_back(r);
      end
    endcase
  endfunction

  // Posts both beats of one write-buffer entry
  task automatic fill_entry(input int id);
    wbuf_fill_t f;
    for (int b = 0; b < 2; b++) begin
      f.wbuf_id = WBUF_ID_W'(id);
      f.beat    = 1'(b);
      f.data    = random_beat();
      m_wbuf[id % WBUF_ENTRIES][b] = f.data;
      @(posedge clk);
      fill_valid <= 1'b1;
      fill       <= f;
    end
    @(posedge clk);
    fill_valid <= 1'b0;
  endtask

  // Sends one request and checks every beat until the last one
  task automatic run_request(input bank_req_t req, input bit stall);
    bank_resp_t held;
    bank_resp_t exp;
    bit         pending;
    bit         fired;
    int         stall_left;
    int         cycles;
    int         beats;
    predict_response(req);
    pending    = 1'b0;
    stall_left = 0;
    cycles     = 0;
    beats      = 0;
    @(posedge clk);
    req_valid  <= 1'b1;
    req_in     <= req;
    resp_ready <= !stall;
    do begin
      @(posedge clk);
    end while (!req_ready);
    req_valid <= 1'b0;
    if (stall) begin
      stall_left = draw_stall();
    end
    while (exp_q.size() > 0) begin
      @(posedge clk);
      cycles++;
      verify_flag("req_ready_o", req_ready, 1'b0);
      if (pending) begin
        verify_flag("resp_valid_o", resp_valid, 1'b1);
        compare_resp("resp_o held", resp, held);
      end
      fired   = resp_valid && resp_ready;
      pending = resp_valid && !resp_ready;
      held    = resp;
      if (fired) begin
        if ((beats == 0) && !stall && (req.op == OP_READ)) begin
          check_count("read latency", cycles, READ_LATENCY);
        end
        exp = exp_q.pop_front();
        compare_resp("resp_o", resp, exp);
        beats++;
      end
      if (stall) begin
        if (fired) begin
          stall_left = draw_stall();
        end
        if (stall_left > 0) begin
          resp_ready <= 1'b0;
          stall_left--;
        end else begin
          resp_ready <= 1'b1;
        end
      end
    end
    // Bank is idle again and nothing extra follows
    @(posedge clk);
    verify_flag("req_ready_o", req_ready, 1'b1);
    verify_flag("resp_valid_o", resp_valid, 1'b0);
    resp_ready <= 1'b0;
  endtask

  task automatic read_empty_cache();
    @(posedge clk);
    verify_flag("req_ready_o", req_ready, 1'b1);
    verify_flag("resp_valid_o", resp_valid, 1'b0);
    run_request(make_req(1, OP_READ, line_addr_of('h0, 0), 0), 1'b0);
    run_request(make_req(3, OP_READ, line_addr_of('h4a1, 11), 0), 1'b0);
  endtask

  task automatic write_then_read();
    fill_entry(3);
    run_request(make_req(2, OP_WRITE, line_addr_of('h1234, 2), 3), 1'b0);
    run_request(make_req(1, OP_READ, line_addr_of('h1234, 2), 0), 1'b0);
  endtask

  // Three tags into set 7, the third replaces the victim way
  task automatic evict_from_full_set();
    fill_entry(4);
    fill_entry(5);
    fill_entry(6);
    run_request(make_req(0, OP_WRITE, line_addr_of('h100, 7), 4), 1'b0);
    run_request(make_req(1, OP_WRITE, line_addr_of('h200, 7), 5), 1'b0);
    run_request(make_req(2, OP_READ, line_addr_of('h100, 7), 0), 1'b0);
    run_request(make_req(3, OP_READ, line_addr_of('h200, 7), 0), 1'b0);
    run_request(make_req(0, OP_WRITE, line_addr_of('h300, 7), 6), 1'b0);
    run_request(make_req(1, OP_READ, line_addr_of('h300, 7), 0), 1'b0);
    run_request(make_req(2, OP_READ, line_addr_of('h100, 7), 0), 1'b0);
    run_request(make_req(3, OP_READ, line_addr_of('h200, 7), 0), 1'b0);
    // Write hit reuses its way and leaves the victim pointer alone
    run_request(make_req(0, OP_WRITE, line_addr_of('h200, 7), 4), 1'b0);
    run_request(make_req(1, OP_WRITE, line_addr_of('h100, 7), 5), 1'b0);
    run_request(make_req(2, OP_READ, line_addr_of('h300, 7), 0), 1'b0);
    run_request(make_req(3, OP_READ, line_addr_of('h200, 7), 0), 1'b0);
  endtask

  task automatic invalidate_lines();
    fill_entry(7);
    run_request(make_req(1, OP_WRITE, line_addr_of('h55, 9), 7), 1'b0);
    run_request(make_req(2, OP_INVAL, line_addr_of('h55, 9), 0), 1'b0);
    run_request(make_req(3, OP_READ, line_addr_of('h55, 9), 0), 1'b0);
    run_request(make_req(0, OP_INVAL, line_addr_of('h55, 9), 0), 1'b0);
    // Absent tag in a full set must not touch the victim way
    run_request(make_req(1, OP_INVAL, line_addr_of('h999, 7), 0), 1'b0);
    run_request(make_req(2, OP_READ, line_addr_of('h300, 7), 0), 1'b0);
  endtask

  task automatic stall_responses();
    fill_entry(8);
    run_request(make_req(2, OP_WRITE, line_addr_of('h7a, 12), 8), 1'b1);
    run_request(make_req(1, OP_READ, line_addr_of('h7a, 12), 0), 1'b1);
    run_request(make_req(3, OP_READ, line_addr_of('h7b, 12), 0), 1'b1);
    run_request(make_req(0, OP_READ, line_addr_of('h7a, 12), 0), 1'b1);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  initial begin
    rst        = 1'b1;
    req_valid  = 1'b0;
    req_in     = '0;
    fill_valid = 1'b0;
    fill       = '0;
    resp_ready = 1'b0;
    clear_reference();
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    read_empty_cache();
    write_then_read();
    evict_from_full_set();
    invalidate_lines();
    stall_responses();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 40
) (
  output logic clk_o
);

  // Starts low, toggles every half period
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire
